//--- hdl/mem_bus_pkg.sv
package mem_bus_pkg;

  // byte address and one data beat
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;

  // AXI response codes, only the two we generate
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    addr_t addr;
  } ar_chan_t;

  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  // address map
  localparam addr_t SRAM_BASE = 32'h8000_0000;
  // uart data register, 8-byte aligned
  localparam addr_t UART_ADDR = 32'ha000_03f8;

endpackage

//--- hdl/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

  // slave controller states
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_READ       = 3'd1,
    ST_READ_RESP  = 3'd2,
    ST_WRITE_DATA = 3'd3,
    ST_WRITE_RESP = 3'd4
  } ctrl_state_e;

  // decoded target of a request
  typedef enum logic [1:0] {
    TGT_SRAM = 2'd0,
    TGT_UART = 2'd1,
    TGT_NONE = 2'd2
  } target_e;

endpackage

//--- hdl/stall_lfsr.sv
`timescale 1ns/1ns

module stall_lfsr #(
  parameter bit STALL_EN = 1'b1
) (
  input  logic clk,
  input  logic arst_n_i,
  output logic stall_o
);

  // any nonzero value works, bit 19 is a tap so zero is never reached
  localparam logic [19:0] SEED = 20'd101;

  logic [19:0] lfsr_q;

  // fibonacci form, taps 19 and 18
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};
    end
  end

  // stall whenever the top bit is low
  assign stall_o = STALL_EN && !lfsr_q[19];

endmodule

//--- hdl/mem_slave_fsm.sv
`timescale 1ns/1ns

module mem_slave_fsm #(
  parameter int SRAM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          arst_n_i,
  input  mem_bus_pkg::ar_chan_t         ar_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output mem_bus_pkg::r_chan_t          r_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  input  mem_bus_pkg::aw_chan_t         aw_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  mem_bus_pkg::w_chan_t          w_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output mem_bus_pkg::b_chan_t          b_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  input  logic                          stall_i,
  output logic                          mem_en_o,
  output logic                          mem_we_o,
  output logic [$clog2(SRAM_WORDS)-1:0] mem_idx_o,
  output mem_bus_pkg::data_t            mem_wdata_o,
  output mem_bus_pkg::strb_t            mem_strb_o,
  input  mem_bus_pkg::data_t            mem_rdata_i,
  output logic                          uart_send_o,
  output logic [7:0]                    uart_byte_o,
  input  logic                          uart_busy_i
);
  import mem_bus_pkg::*;
  import mem_ctrl_pkg::*;

  localparam int IDX_W = $clog2(SRAM_WORDS);
  // one past the last sram byte, 33 bits so it cannot wrap
  localparam logic [32:0] SRAM_LIMIT = {1'b0, SRAM_BASE} + 33'(8 * SRAM_WORDS);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  target_e     tgt_q;
  target_e     ar_tgt;
  target_e     aw_tgt;
  addr_t       addr_q;
  data_t       rdata_q;
  resp_e       resp_q;
  logic        ar_hs;
  logic        aw_hs;
  logic        w_hs;
  logic        r_hs;
  logic        b_hs;

  function automatic target_e decode(input addr_t addr);
    if (addr >= SRAM_BASE && {1'b0, addr} < SRAM_LIMIT) begin
      return TGT_SRAM;
    end else if (addr[31:3] == UART_ADDR[31:3]) begin
      return TGT_UART;
    end
    return TGT_NONE;
  endfunction

  // 64-bit word index inside the sram window
  function automatic logic [IDX_W-1:0] sram_idx(input addr_t addr);
    addr_t offset;
    offset = addr - SRAM_BASE;
    return offset[IDX_W+2:3];
  endfunction

  function automatic resp_e resp_for(input target_e tgt);
    return (tgt == TGT_NONE) ? RESP_DECERR : RESP_OKAY;
  endfunction

  assign ar_tgt = decode(ar_i.addr);
  assign aw_tgt = decode(aw_i.addr);

  // reads win over writes in idle
  assign arready_o = (state_q == ST_IDLE) && !stall_i;
  assign awready_o = (state_q == ST_IDLE) && !stall_i && !arvalid_i;
  // uart data waits until the previous frame is out
  assign wready_o  = (state_q == ST_WRITE_DATA) && wvalid_i && !stall_i &&
                     ((tgt_q != TGT_UART) || !uart_busy_i);
  assign rvalid_o  = (state_q == ST_READ_RESP);
  assign bvalid_o  = (state_q == ST_WRITE_RESP);

  assign ar_hs = arvalid_i && arready_o;
  assign aw_hs = awvalid_i && awready_o;
  assign w_hs  = wvalid_i && wready_o;
  assign r_hs  = rvalid_o && rready_i;
  assign b_hs  = bvalid_o && bready_i;

  // sram port, read starts on the accepting edge
  assign mem_en_o    = (ar_hs && ar_tgt == TGT_SRAM) || (w_hs && tgt_q == TGT_SRAM);
  assign mem_we_o    = w_hs && (tgt_q == TGT_SRAM);
  assign mem_idx_o   = (state_q == ST_WRITE_DATA) ? sram_idx(addr_q) : sram_idx(ar_i.addr);
  assign mem_wdata_o = w_i.data;
  assign mem_strb_o  = w_i.strb;

  // only byte 0 goes out on the serial line
  assign uart_send_o = w_hs && (tgt_q == TGT_UART) && w_i.strb[0];
  assign uart_byte_o = w_i.data[7:0];

  assign r_o.data = rdata_q;
  assign r_o.resp = resp_q;
  assign b_o.resp = resp_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (ar_hs) begin
          state_d = ST_READ;
        end else if (aw_hs) begin
          state_d = ST_WRITE_DATA;
        end
      end
      ST_READ: begin
        if (!stall_i) begin
          state_d = ST_READ_RESP;
        end
      end
      // a response handshake completes even on a stalled cycle
      ST_READ_RESP: begin
        if (r_hs) begin
          state_d = ST_IDLE;
        end
      end
      ST_WRITE_DATA: begin
        if (w_hs) begin
          state_d = ST_WRITE_RESP;
        end
      end
      ST_WRITE_RESP: begin
        if (b_hs) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      tgt_q   <= TGT_NONE;
    end else begin
      state_q <= state_d;
      if (ar_hs) begin
        tgt_q <= ar_tgt;
      end else if (aw_hs) begin
        tgt_q <= aw_tgt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      addr_q <= ar_i.addr;
      resp_q <= resp_for(ar_tgt);
    end else if (aw_hs) begin
      addr_q <= aw_i.addr;
      resp_q <= resp_for(aw_tgt);
    end
    // sram data is valid the cycle after enable
    if (state_q == ST_READ && !stall_i) begin
      rdata_q <= (tgt_q == TGT_SRAM) ? mem_rdata_i : '0;
    end
  end

endmodule

//--- hdl/sram_array.sv
`timescale 1ns/1ns

module sram_array #(
  parameter int SRAM_WORDS = 256
) (
  input  logic                          clk,
  input  logic                          en_i,
  input  logic                          we_i,
  input  logic [$clog2(SRAM_WORDS)-1:0] idx_i,
  input  mem_bus_pkg::data_t            wdata_i,
  input  mem_bus_pkg::strb_t            strb_i,
  output mem_bus_pkg::data_t            rdata_o
);
  import mem_bus_pkg::*;

  localparam int NUM_BYTES = $bits(strb_t);

  data_t mem_q [SRAM_WORDS];

  // write under byte strobes, otherwise read into the output register
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (strb_i[b]) begin
            mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[idx_i];
      end
    end
  end

endmodule

//--- hdl/uart_tx_port.sv
`timescale 1ns/1ns

module uart_tx_port #(
  parameter int BAUD_DIV = 4
) (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       send_i,
  input  logic [7:0] byte_i,
  output logic       busy_o,
  output logic       tx_o
);

  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BAUD_DIV - 1);
  // start + 8 data + stop
  localparam logic [3:0] LAST_BIT = 4'd9;

  logic [CNT_W-1:0] baud_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic [9:0]       shift_q;
  logic             busy_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      shift_q    <= '1;
      busy_q     <= 1'b0;
    end else if (send_i && !busy_q) begin
      // frame goes lsb first, start bit in bit 0
      shift_q    <= {1'b1, byte_i, 1'b0};
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b1;
    end else if (busy_q) begin
      if (baud_cnt_q == BAUD_LAST) begin
        baud_cnt_q <= '0;
        // refill with ones so the line idles high
        shift_q    <= {1'b1, shift_q[9:1]};
        if (bit_cnt_q == LAST_BIT) begin
          busy_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end
    end
  end

  assign tx_o   = shift_q[0];
  assign busy_o = busy_q;

endmodule

//--- hdl/mem_subsys_top.sv
`timescale 1ns/1ns

module mem_subsys_top #(
  parameter int SRAM_WORDS = 256,
  parameter int BAUD_DIV   = 4,
  parameter bit STALL_EN   = 1'b1
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  mem_bus_pkg::ar_chan_t ar_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output mem_bus_pkg::r_chan_t  r_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  input  mem_bus_pkg::aw_chan_t aw_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  mem_bus_pkg::w_chan_t  w_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output mem_bus_pkg::b_chan_t  b_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  output logic                  uart_tx_o
);
  import mem_bus_pkg::*;

  localparam int IDX_W = $clog2(SRAM_WORDS);

  logic             stall;
  logic             mem_en;
  logic             mem_we;
  logic [IDX_W-1:0] mem_idx;
  data_t            mem_wdata;
  strb_t            mem_strb;
  data_t            mem_rdata;
  logic             uart_send;
  logic [7:0]       uart_byte;
  logic             uart_busy;

  stall_lfsr #(
    .STALL_EN (STALL_EN)
  ) u_stall (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .stall_o  (stall)
  );

  mem_slave_fsm #(
    .SRAM_WORDS (SRAM_WORDS)
  ) u_fsm (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .ar_i        (ar_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .r_o         (r_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .aw_i        (aw_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .w_i         (w_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .b_o         (b_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .stall_i     (stall),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_idx_o   (mem_idx),
    .mem_wdata_o (mem_wdata),
    .mem_strb_o  (mem_strb),
    .mem_rdata_i (mem_rdata),
    .uart_send_o (uart_send),
    .uart_byte_o (uart_byte),
    .uart_busy_i (uart_busy)
  );

  sram_array #(
    .SRAM_WORDS (SRAM_WORDS)
  ) u_sram (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .idx_i   (mem_idx),
    .wdata_i (mem_wdata),
    .strb_i  (mem_strb),
    .rdata_o (mem_rdata)
  );

  uart_tx_port #(
    .BAUD_DIV (BAUD_DIV)
  ) u_uart (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .send_i   (uart_send),
    .byte_i   (uart_byte),
    .busy_o   (uart_busy),
    .tx_o     (uart_tx_o)
  );

endmodule

//--- tests/mem_subsys_assert.sv
`timescale 1ns/1ns

module mem_subsys_assert (
  input logic                 clk,
  input logic                 arst_n_i,
  input logic                 arvalid_i,
  input logic                 arready_i,
  input logic                 awvalid_i,
  input logic                 awready_i,
  input mem_bus_pkg::r_chan_t r_i,
  input logic                 rvalid_i,
  input logic                 rready_i,
  input mem_bus_pkg::b_chan_t b_i,
  input logic                 bvalid_i,
  input logic                 bready_i
);

  logic rd_pend_q;
  logic wr_pend_q;
  logic any_fail;
  bit   r_hold_bad;
  bit   b_hold_bad;
  bit   reset_bad;
  bit   accept_bad;
  bit   r_pair_bad;
  bit   b_pair_bad;

  assign any_fail = r_hold_bad || b_hold_bad || reset_bad || accept_bad ||
                    r_pair_bad || b_pair_bad;

  // outstanding read or write, one at most
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_pend_q <= 1'b0;
      wr_pend_q <= 1'b0;
    end else begin
      if (arvalid_i && arready_i) begin
        rd_pend_q <= 1'b1;
      end else if (rvalid_i && rready_i) begin
        rd_pend_q <= 1'b0;
      end
      if (awvalid_i && awready_i) begin
        wr_pend_q <= 1'b1;
      end else if (bvalid_i && bready_i) begin
        wr_pend_q <= 1'b0;
      end
    end
  end

  r_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      rvalid_i && !rready_i |=> rvalid_i && $stable(r_i))
    else begin
      r_hold_bad = 1'b1;
      $error("r channel dropped or changed under back-pressure");
    end

  b_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      bvalid_i && !bready_i |=> bvalid_i && $stable(b_i))
    else begin
      b_hold_bad = 1'b1;
      $error("b channel dropped or changed under back-pressure");
    end

  quiet_in_reset: assert property (@(posedge clk) !arst_n_i |-> !rvalid_i && !bvalid_i)
    else begin
      reset_bad = 1'b1;
      $error("response valid while reset is active");
    end

  // no new request while anything is outstanding
  accept_when_free: assert property (@(posedge clk) disable iff (!arst_n_i)
      (rvalid_i || bvalid_i || rd_pend_q || wr_pend_q) |-> !arready_i && !awready_i)
    else begin
      accept_bad = 1'b1;
      $error("request ready raised while a transaction is pending");
    end

  r_follows_ar: assert property (@(posedge clk) disable iff (!arst_n_i)
      rvalid_i && rready_i |-> rd_pend_q)
    else begin
      r_pair_bad = 1'b1;
      $error("r transfer without an accepted read");
    end

  b_follows_aw: assert property (@(posedge clk) disable iff (!arst_n_i)
      bvalid_i && bready_i |-> wr_pend_q)
    else begin
      b_pair_bad = 1'b1;
      $error("b transfer without an accepted write");
    end

endmodule

bind mem_subsys_top mem_subsys_assert u_assert (
  .clk       (clk),
  .arst_n_i  (arst_n_i),
  .arvalid_i (arvalid_i),
  .arready_i (arready_o),
  .awvalid_i (awvalid_i),
  .awready_i (awready_o),
  .r_i       (r_o),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .b_i       (b_o),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i)
);

//--- tests/mem_subsys_tb.sv
`timescale 1ns/1ns

module mem_subsys_tb;
  import mem_bus_pkg::*;

  localparam int SRAM_WORDS = 256;
  localparam int BAUD_DIV   = 4;
  localparam int MIXED_RUNS = 200;
  localparam int TIMEOUT    = 500;
  localparam int DRIVE_DLY  = 10;
  localparam int CH_AR      = 0;
  localparam int CH_AW      = 1;
  localparam int CH_W       = 2;

  logic     clk;
  logic     arst_n;
  ar_chan_t ar_req;
  logic     arvalid;
  logic     arready;
  r_chan_t  r_rsp;
  logic     rvalid;
  logic     rready;
  aw_chan_t aw_req;
  logic     awvalid;
  logic     awready;
  w_chan_t  w_req;
  logic     wvalid;
  logic     wready;
  b_chan_t  b_rsp;
  logic     bvalid;
  logic     bready;
  logic     uart_tx;

  // byte-wise reference of the sram, known marks bytes written so far
  data_t      model_mem [SRAM_WORDS];
  bit [7:0]   known [SRAM_WORDS];
  int         written_idx [$];
  logic [7:0] uart_expect [$];
  int         uart_seen;
  bit         in_frame;
  r_chan_t    last_r;
  b_chan_t    last_b;

  mem_subsys_top #(
    .SRAM_WORDS (SRAM_WORDS),
    .BAUD_DIV   (BAUD_DIV),
    .STALL_EN   (1'b1)
  ) dut_i (
    .clk       (clk),
    .arst_n_i  (arst_n),
    .ar_i      (ar_req),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .r_o       (r_rsp),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .aw_i      (aw_req),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .w_i       (w_req),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .b_o       (b_rsp),
    .bvalid_o  (bvalid),
    .bready_i  (bready),
    .uart_tx_o (uart_tx)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    stop_on_error();
  endtask

  task automatic check_value(input string test, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERROR %s: expected %h, actual %h", test, exp, act);
      stop_on_error();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  function automatic logic ready_of(input int chan);
    case (chan)
      CH_AR:   return arready;
      CH_AW:   return awready;
      default: return wready;
    endcase
  endfunction

  // ready is sampled mid-cycle, the transfer happens on the next edge
  task automatic wait_accept(input string what, input int chan);
    int   n;
    logic taken;
    n = 0;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = ready_of(chan);
      next_cycle();
      n++;
      if (!taken && n > TIMEOUT) begin
        report_timeout(what);
      end
    end
  endtask

  // master ready comes up after a random number of cycles
  task automatic wait_response(input string what, input bit is_read);
    int   n;
    logic done;
    n = 0;
    done = 1'b0;
    while (!done) begin
      if ($urandom_range(2, 0) == 0) begin
        rready = is_read ? 1'b1 : rready;
        bready = is_read ? bready : 1'b1;
      end
      @(negedge clk);
      done = is_read ? (rvalid && rready) : (bvalid && bready);
      last_r = r_rsp;
      last_b = b_rsp;
      next_cycle();
      n++;
      if (!done && n > TIMEOUT) begin
        report_timeout(what);
      end
    end
    rready = 1'b0;
    bready = 1'b0;
  endtask

  function automatic bit in_sram(input addr_t addr);
    return addr >= SRAM_BASE && addr < SRAM_BASE + addr_t'(8 * SRAM_WORDS);
  endfunction

  function automatic bit is_uart(input addr_t addr);
    return addr[31:3] == UART_ADDR[31:3];
  endfunction

  function automatic int word_index(input addr_t addr);
    return int'((addr - SRAM_BASE) >> 3);
  endfunction

  function automatic addr_t sram_addr(input int idx);
    return SRAM_BASE + addr_t'(idx * 8) + addr_t'($urandom_range(7, 0));
  endfunction

  // below the sram window, or above it but short of the uart page
  function automatic addr_t unmapped_addr();
    if ($urandom_range(1, 0) == 0) begin
      return {1'b0, 31'($urandom())};
    end
    return sram_addr(SRAM_WORDS) + addr_t'($urandom_range(32'h0fff_0000, 0));
  endfunction

  function automatic data_t random_data();
    return {$urandom(), $urandom()};
  endfunction

  function automatic data_t byte_mask(input bit [7:0] strb);
    data_t mask;
    for (int k = 0; k < 8; k++) begin
      mask[8*k +: 8] = {8{strb[k]}};
    end
    return mask;
  endfunction

  task automatic read_check(input string test, input addr_t addr);
    data_t exp;
    data_t mask;
    resp_e exp_resp;
    exp = '0;
    mask = '1;
    exp_resp = is_uart(addr) ? RESP_OKAY : RESP_DECERR;
    if (in_sram(addr)) begin
      exp = model_mem[word_index(addr)];
      mask = byte_mask(known[word_index(addr)]);
      exp_resp = RESP_OKAY;
    end
    ar_req.addr = addr;
    arvalid = 1'b1;
    wait_accept("read address", CH_AR);
    arvalid = 1'b0;
    wait_response("read response", 1'b1);
    check_value({test, " data"}, exp & mask, last_r.data & mask);
    check_value({test, " resp"}, 64'(exp_resp), 64'(last_r.resp));
  endtask

  task automatic write_check(input string test, input addr_t addr, input data_t data,
                             input strb_t strb);
    int    idx;
    int    k;
    resp_e exp_resp;
    aw_req.addr = addr;
    awvalid = 1'b1;
    wait_accept("write address", CH_AW);
    awvalid = 1'b0;
    w_req.data = data;
    w_req.strb = strb;
    wvalid = 1'b1;
    wait_accept("write data", CH_W);
    wvalid = 1'b0;
    exp_resp = (in_sram(addr) || is_uart(addr)) ? RESP_OKAY : RESP_DECERR;
    if (in_sram(addr)) begin
      idx = word_index(addr);
      for (k = 0; k < 8; k++) begin
        if (strb[k]) begin
          model_mem[idx][8*k +: 8] = data[8*k +: 8];
        end
      end
      if (known[idx] == 8'h00 && strb != 8'h00) begin
        written_idx.push_back(idx);
      end
      known[idx] = known[idx] | strb;
    end else if (is_uart(addr) && strb[0]) begin
      uart_expect.push_back(data[7:0]);
    end
    wait_response("write response", 1'b0);
    check_value({test, " resp"}, 64'(exp_resp), 64'(last_b.resp));
  endtask

  task automatic wait_uart_idle();
    int n;
    n = 0;
    while (uart_seen != uart_expect.size() || in_frame) begin
      next_cycle();
      n++;
      if (n > TIMEOUT) begin
        report_timeout("the serial frames to finish");
      end
    end
  endtask

  // sampled at the falling edge, every bit checked on each of its cycles
  always begin : uart_sampler
    logic [9:0] frame;
    int         n;
    @(negedge clk);
    if (arst_n && uart_tx === 1'b0) begin
      if (uart_seen >= uart_expect.size()) begin
        $display("serial frame started with no byte pending");
        stop_on_error();
      end
      frame = {1'b1, uart_expect[uart_seen], 1'b0};
      in_frame = 1'b1;
      for (n = 1; n < 10 * BAUD_DIV; n++) begin
        @(negedge clk);
        check_value("uart frame bit", 64'(frame[n / BAUD_DIV]), 64'(uart_tx));
      end
      uart_seen++;
      in_frame = 1'b0;
    end
  end

  always @(negedge clk) begin
    if (dut_i.u_assert.any_fail) begin
      $display("a bound assertion failed");
      stop_on_error();
    end
  end

  initial begin : stimulus
    int idx;
    void'($urandom(32'ha091));
    arst_n  = 1'b0;
    ar_req  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    aw_req  = '0;
    awvalid = 1'b0;
    w_req   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    next_cycle();

    // both ends of the window, then strobed writes with read-back
    write_check("sram first word", SRAM_BASE, random_data(), 8'hff);
    write_check("sram last word", sram_addr(SRAM_WORDS - 1), random_data(), 8'hff);
    repeat (20) begin
      idx = $urandom_range(SRAM_WORDS - 1, 0);
      write_check("sram strobed write", sram_addr(idx), random_data(), strb_t'($urandom()));
      read_check("sram read back", sram_addr(idx));
    end

    // just outside the window on both sides
    read_check("unmapped read", SRAM_BASE - 32'd8);
    write_check("unmapped write low", SRAM_BASE - 32'd8, random_data(), 8'hff);
    write_check("unmapped write high", sram_addr(SRAM_WORDS), random_data(), 8'hff);
    read_check("neighbour first word", SRAM_BASE);
    read_check("neighbour last word", sram_addr(SRAM_WORDS - 1));

    write_check("uart write", UART_ADDR, random_data(), 8'h01);
    write_check("uart back to back a", UART_ADDR, random_data(), 8'hff);
    write_check("uart back to back b", UART_ADDR, random_data(), 8'h0f);
    read_check("uart read", UART_ADDR);
    wait_uart_idle();

    repeat (MIXED_RUNS) begin
      case ($urandom_range(9, 0))
        0, 1, 2, 3: begin
          idx = $urandom_range(SRAM_WORDS - 1, 0);
          write_check("mixed sram write", sram_addr(idx), random_data(), strb_t'($urandom()));
        end
        4, 5: begin
          idx = written_idx[$urandom_range(written_idx.size() - 1, 0)];
          read_check("mixed sram read", sram_addr(idx));
        end
        6: read_check("mixed unmapped read", unmapped_addr());
        7: write_check("mixed unmapped write", unmapped_addr(), random_data(), 8'hff);
        8: write_check("mixed uart write", UART_ADDR, random_data(), strb_t'($urandom()));
        default: read_check("mixed uart read", UART_ADDR);
      endcase
    end
    wait_uart_idle();

    if (dut_i.u_assert.any_fail) begin
      stop_on_error();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- files.f
hdl/mem_bus_pkg.sv
hdl/mem_ctrl_pkg.sv
hdl/stall_lfsr.sv
hdl/mem_slave_fsm.sv
hdl/sram_array.sv
hdl/uart_tx_port.sv
hdl/mem_subsys_top.sv
tests/mem_subsys_assert.sv
tests/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mem_subsys_tb \
  --Mdir obj_dir -o mem_subsys_sim \
  -f files.f

./obj_dir/mem_subsys_sim | tee sim.log

if grep -q "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
